// File: wfd_pkg.sv
// shared widths, channel count and the header/data/trailer views of the 64-bit DAQ word
package wfd_pkg;

    localparam int NUM_CHAN    = 5;   // channel FPGAs on the board
    localparam int CHAN_IDX_W  = 3;
    localparam int TRIG_NUM_W  = 24;
    localparam int CHAN_DATA_W = 32;  // serial link stream word
    localparam int DAQ_W       = 64;  // AMC13 event word
    localparam int BOARD_ID_W  = 3;
    localparam int WORD_CNT_W  = 20;

    ////////////////////////////////////////////////////
    // DAQ word views, msb first

    typedef struct packed {
        logic [TRIG_NUM_W-1:0]                                   trig_num;
        logic [BOARD_ID_W-1:0]                                   board_id;
        logic [CHAN_IDX_W-1:0]                                   num_chan;
        logic [DAQ_W-TRIG_NUM_W-BOARD_ID_W-CHAN_IDX_W-1:0]       pad;      // 34 bits
    } daq_hdr_t;

    typedef struct packed {
        logic [CHAN_IDX_W-1:0]                   chan_idx;  // source channel
        logic [DAQ_W-CHAN_IDX_W-CHAN_DATA_W-1:0] pad;
        logic [CHAN_DATA_W-1:0]                  payload;
    } daq_dat_t;

    typedef struct packed {
        logic [TRIG_NUM_W-1:0]                  trig_num;   // repeats the header
        logic [DAQ_W-TRIG_NUM_W-WORD_CNT_W-1:0] pad;
        logic [WORD_CNT_W-1:0]                  word_count; // data words only
    } daq_trl_t;

    // one word, decoded by the daq_header / daq_trailer marks
    typedef union packed {
        daq_hdr_t         hdr;
        daq_dat_t         dat;
        daq_trl_t         trl;
        logic [DAQ_W-1:0] raw;
    } daq_word_u;

endpackage

// File: trigger_manager.sv
// ext trigger synchronizer and edge detect, go/done/arm sequencer, trigger number counter
`timescale 1ns/1ps

module trigger_manager #(
    parameter int NUM_CHAN = wfd_pkg::NUM_CHAN
) (
    input  logic                           clk125,
    input  logic                           arst_n,
    input  logic                           ext_trig,       // front panel, async level
    input  logic [NUM_CHAN-1:0]            acq_dones,      // done strobes from channels
    input  logic                           fifo_in_ready,
    output logic [NUM_CHAN-1:0]            acq_trigs,      // go, one cycle on all bits
    output logic [NUM_CHAN-1:0]            trig_arm,       // level to each channel
    output logic                           fifo_in_valid,
    output logic [wfd_pkg::TRIG_NUM_W-1:0] fifo_in_data    // also the trigger counter
);

    localparam logic [1:0] ST_ARMED = 2'd0;
    localparam logic [1:0] ST_WAIT  = 2'd1;  // go sent, collecting dones
    localparam logic [1:0] ST_PUSH  = 2'd2;  // number offered to the fifo

    logic [1:0]          state;
    logic                trig_meta;
    logic                trig_sync;
    logic                trig_dly;
    logic                trig_edge;
    logic [NUM_CHAN-1:0] done_lat;
    logic [NUM_CHAN-1:0] done_seen;

    ////////////////////////////////////////////////////
    // bring ext_trig into clk125, then find the rising edge

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
            trig_dly  <= 1'b0;
        end else begin
            trig_meta <= ext_trig;   // may go metastable
            trig_sync <= trig_meta;
            trig_dly  <= trig_sync;  // edge register
        end
    end

    assign trig_edge = trig_sync & ~trig_dly;
    assign done_seen = done_lat | acq_dones;  // dones latched so far plus this cycle

    ////////////////////////////////////////////////////
    // arm / wait-dones / push sequencer

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_ARMED;
            acq_trigs     <= '0;
            trig_arm      <= '1;
            done_lat      <= '0;
            fifo_in_valid <= 1'b0;
            fifo_in_data  <= '0;
        end else begin
            acq_trigs <= '0;  // go is a single cycle strobe
            case (state)
                ST_ARMED: begin
                    // edge dropped when the fifo has no room for its number
                    if (trig_edge && fifo_in_ready) begin
                        acq_trigs <= '1;
                        trig_arm  <= '0;   // disarm together with go
                        done_lat  <= '0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    done_lat <= done_seen;
                    if (&done_seen) begin
                        fifo_in_valid <= 1'b1;
                        state         <= ST_PUSH;
                    end
                end
                ST_PUSH: begin
                    if (fifo_in_ready) begin
                        fifo_in_valid <= 1'b0;
                        fifo_in_data  <= fifo_in_data + 1'b1;  // next trigger number
                        trig_arm      <= '1;
                        state         <= ST_ARMED;
                    end
                end
                default: state <= ST_ARMED;
            endcase
        end
    end

    // go never stretches, even with an edge right after re-arm
    assert property (@(posedge clk125) disable iff (!arst_n)
        |acq_trigs |=> !(|acq_trigs));

    // number held until the fifo takes it
    assert property (@(posedge clk125) disable iff (!arst_n)
        fifo_in_valid && !fifo_in_ready |=> fifo_in_valid && $stable(fifo_in_data));

endmodule

// File: trig_num_fifo.sv
// register-array FIFO of trigger numbers with a registered output stage
`timescale 1ns/1ps

module trig_num_fifo #(
    parameter int DEPTH = 8,                    // power of two
    parameter int WIDTH = wfd_pkg::TRIG_NUM_W
) (
    input  logic             clk125,
    input  logic             arst_n,
    input  logic             fifo_in_valid,
    input  logic [WIDTH-1:0] fifo_in_data,
    output logic             fifo_in_ready,   // not full
    output logic             fifo_out_valid,
    output logic [WIDTH-1:0] fifo_out_data,
    input  logic             fifo_out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;      // words in the array, output reg not included
    logic             push;
    logic             load;
    logic             bypass;
    logic             mem_rd;
    logic             mem_wr;

    assign fifo_in_ready = (count != CNT_W'(DEPTH));
    assign push   = fifo_in_valid && fifo_in_ready;
    assign load   = !fifo_out_valid || fifo_out_ready;   // output reg free next edge
    assign bypass = push && load && (count == '0);       // empty, straight to output
    assign mem_rd = load && (count != '0);
    assign mem_wr = push && !bypass;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            fifo_out_valid <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({mem_wr, mem_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (load) fifo_out_valid <= mem_rd || bypass;
        end
    end

    // storage and output word
    always_ff @(posedge clk125) begin
        if (mem_wr) mem[wr_ptr] <= fifo_in_data;
        if (mem_rd) fifo_out_data <= mem[rd_ptr];
        else if (bypass) fifo_out_data <= fifo_in_data;
    end

    assert property (@(posedge clk125) disable iff (!arst_n) count <= CNT_W'(DEPTH));

    // empty count only where the pointers have met, so count never drops below empty
    assert property (@(posedge clk125) disable iff (!arst_n)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

// File: readout_manager.sv
// DAQ event builder: header per trigger number, channel streams in order, trailer with count
`timescale 1ns/1ps

module readout_manager #(
    parameter int NUM_CHAN = wfd_pkg::NUM_CHAN
) (
    input  logic                                     clk125,
    input  logic                                     arst_n,
    input  logic [wfd_pkg::BOARD_ID_W-1:0]           board_id,
    input  logic                                     fifo_out_valid,  // trigger number fifo
    input  logic [wfd_pkg::TRIG_NUM_W-1:0]           fifo_out_data,
    output logic                                     fifo_out_ready,
    input  logic [NUM_CHAN-1:0]                      chan_tvalid,     // channel streams
    input  logic [NUM_CHAN-1:0]                      chan_tlast,
    input  logic [NUM_CHAN*wfd_pkg::CHAN_DATA_W-1:0] chan_tdata,
    output logic [NUM_CHAN-1:0]                      chan_tready,
    output logic                                     daq_valid,       // AMC13 side
    output logic                                     daq_header,
    output logic                                     daq_trailer,
    output logic [wfd_pkg::DAQ_W-1:0]                daq_data,
    input  logic                                     daq_ready
);

    import wfd_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;  // waiting on a trigger number
    localparam logic [1:0] ST_DATA = 2'd1;  // walking the channels
    localparam logic [1:0] ST_TRL  = 2'd2;

    logic [1:0]             state;
    logic [CHAN_IDX_W-1:0]  chan_sel;   // rx switch select
    logic [TRIG_NUM_W-1:0]  evt_num;
    logic [WORD_CNT_W-1:0]  word_cnt;
    logic                   out_free;
    logic                   hdr_go;
    logic                   dat_go;
    logic                   trl_go;
    logic [CHAN_DATA_W-1:0] sel_data;
    daq_word_u              nxt_word;

    ////////////////////////////////////////////////////
    // handshakes, all gated by room in the output reg

    assign out_free       = !daq_valid || daq_ready;  // current word gone or none held
    assign fifo_out_ready = out_free && (state == ST_IDLE);
    assign hdr_go         = fifo_out_valid && fifo_out_ready;
    assign trl_go         = out_free && (state == ST_TRL);
    assign sel_data       = chan_tdata[chan_sel*CHAN_DATA_W +: CHAN_DATA_W];

    always_comb begin
        chan_tready = '0;
        if (state == ST_DATA && out_free) chan_tready[chan_sel] = 1'b1;  // selected lane only
    end

    assign dat_go = chan_tvalid[chan_sel] && chan_tready[chan_sel];

    // next DAQ word, view picked by state
    always_comb begin
        nxt_word.raw = '0;
        if (state == ST_IDLE) begin
            nxt_word.hdr.trig_num = fifo_out_data;
            nxt_word.hdr.board_id = board_id;
            nxt_word.hdr.num_chan = CHAN_IDX_W'(NUM_CHAN);
        end else if (state == ST_DATA) begin
            nxt_word.dat.chan_idx = chan_sel;
            nxt_word.dat.payload  = sel_data;
        end else begin
            nxt_word.trl.trig_num   = evt_num;
            nxt_word.trl.word_count = word_cnt;   // complete once in ST_TRL
        end
    end

    ////////////////////////////////////////////////////
    // event sequencer and output marks

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            chan_sel    <= '0;
            word_cnt    <= '0;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            if (out_free) begin   // hold the marks while the sink stalls
                daq_valid   <= hdr_go || dat_go || trl_go;
                daq_header  <= hdr_go;
                daq_trailer <= trl_go;
            end
            case (state)
                ST_IDLE: begin
                    if (hdr_go) begin
                        chan_sel <= '0;
                        word_cnt <= '0;
                        state    <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (dat_go) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (chan_tlast[chan_sel]) begin
                            // last channel done, close the event
                            if (chan_sel == CHAN_IDX_W'(NUM_CHAN - 1)) state <= ST_TRL;
                            else chan_sel <= chan_sel + 1'b1;
                        end
                    end
                end
                ST_TRL: begin
                    if (trl_go) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload regs
    always_ff @(posedge clk125) begin
        if (hdr_go || dat_go || trl_go) daq_data <= nxt_word.raw;
        if (hdr_go) evt_num <= fifo_out_data;  // kept for the trailer
    end

    assert property (@(posedge clk125) disable iff (!arst_n) !(daq_header && daq_trailer));

    // one channel pulled at a time
    assert property (@(posedge clk125) disable iff (!arst_n) $onehot0(chan_tready));

endmodule

// File: wfd_top.sv
// master controller trigger and readout path: trigger manager, number FIFO, readout manager
`timescale 1ns/1ps

module wfd_top #(
    parameter int NUM_CHAN   = wfd_pkg::NUM_CHAN,
    parameter int FIFO_DEPTH = 8                    // triggers queued ahead of readout
) (
    input  logic                                     clk125,
    input  logic                                     arst_n,
    input  logic                                     ext_trig,     // front panel trigger
    input  logic [wfd_pkg::BOARD_ID_W-1:0]           board_id,
    output logic [NUM_CHAN-1:0]                      acq_trigs,    // go to channel FPGAs
    input  logic [NUM_CHAN-1:0]                      acq_dones,
    output logic [NUM_CHAN-1:0]                      trig_arm,
    input  logic [NUM_CHAN-1:0]                      chan_tvalid,  // channel rx streams
    input  logic [NUM_CHAN-1:0]                      chan_tlast,
    input  logic [NUM_CHAN*wfd_pkg::CHAN_DATA_W-1:0] chan_tdata,
    output logic [NUM_CHAN-1:0]                      chan_tready,
    output logic                                     daq_valid,    // to AMC13 link
    output logic                                     daq_header,
    output logic                                     daq_trailer,
    output logic [wfd_pkg::DAQ_W-1:0]                daq_data,
    input  logic                                     daq_ready
);

    import wfd_pkg::*;

    logic                  fifo_in_valid;   // tm to fifo
    logic                  fifo_in_ready;
    logic [TRIG_NUM_W-1:0] fifo_in_data;
    logic                  fifo_out_valid;  // fifo to readout
    logic                  fifo_out_ready;
    logic [TRIG_NUM_W-1:0] fifo_out_data;

    trigger_manager #(
        .NUM_CHAN(NUM_CHAN)
    ) i_tm (
        .clk125        (clk125),
        .arst_n        (arst_n),
        .ext_trig      (ext_trig),
        .acq_dones     (acq_dones),
        .fifo_in_ready (fifo_in_ready),
        .acq_trigs     (acq_trigs),
        .trig_arm      (trig_arm),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_data  (fifo_in_data)
    );

    trig_num_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(TRIG_NUM_W)
    ) i_fifo (
        .clk125         (clk125),
        .arst_n         (arst_n),
        .fifo_in_valid  (fifo_in_valid),
        .fifo_in_data   (fifo_in_data),
        .fifo_in_ready  (fifo_in_ready),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_ready (fifo_out_ready)
    );

    readout_manager #(
        .NUM_CHAN(NUM_CHAN)
    ) i_rm (
        .clk125         (clk125),
        .arst_n         (arst_n),
        .board_id       (board_id),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_ready (fifo_out_ready),
        .chan_tvalid    (chan_tvalid),
        .chan_tlast     (chan_tlast),
        .chan_tdata     (chan_tdata),
        .chan_tready    (chan_tready),
        .daq_valid      (daq_valid),
        .daq_header     (daq_header),
        .daq_trailer    (daq_trailer),
        .daq_data       (daq_data),
        .daq_ready      (daq_ready)
    );

endmodule

// File: tb_wfd_top.sv
// testbench for wfd_top: clock, reset, trigger driver, channel models, expected events, checks
`timescale 1ns/1ps

module tb_wfd_top;

    import wfd_pkg::*;

    localparam int          N_TRIG   = 30;            // front panel trigger attempts
    localparam int          N_TESTS  = 6;
    localparam logic [2:0]  BOARD_ID = 3'd5;
    localparam int unsigned SEED     = 32'h504ffe2b;

    logic                            clk125 = 1'b0;
    logic                            arst_n;
    logic                            ext_trig;
    logic [BOARD_ID_W-1:0]           board_id;
    logic [NUM_CHAN-1:0]             acq_trigs;
    logic [NUM_CHAN-1:0]             acq_dones;
    logic [NUM_CHAN-1:0]             trig_arm;
    logic [NUM_CHAN-1:0]             chan_tvalid;
    logic [NUM_CHAN-1:0]             chan_tlast;
    logic [NUM_CHAN*CHAN_DATA_W-1:0] chan_tdata;
    logic [NUM_CHAN-1:0]             chan_tready;
    logic                            daq_valid;
    logic                            daq_header;
    logic                            daq_trailer;
    logic [DAQ_W-1:0]                daq_data;
    logic                            daq_ready;

    logic [65:0]            exp_q [$];               // {header, trailer, word}, in arrival order
    logic [65:0]            exp_head  = '0;          // front of exp_q as of the last edge
    logic                   exp_avail = 1'b0;
    logic [65:0]            held_word = '0;          // DAQ outputs one edge back
    logic [NUM_CHAN-1:0]    dones_pending = '0;
    logic [32:0]            chan_q [NUM_CHAN][$];    // {last, payload} per channel
    logic [CHAN_DATA_W-1:0] ev_words [NUM_CHAN][4];  // words of the event being built
    int                     ev_len    [NUM_CHAN] = '{default: 0};
    int                     countdown [NUM_CHAN] = '{default: 0};  // cycles to done, 0 idle
    int                     go_cnt = 0;
    int                     hdr_cnt = 0;
    int                     ev_idx = 0;
    int                     chans_done = 0;
    logic                   arst_q = 1'b0;
    int                     errs [N_TESTS] = '{default: 0};
    int                     hits [N_TESTS] = '{default: 0};  // times each check was reached
    string                  test_name [N_TESTS] = '{"reset_state", "trigger_handling",
                                                    "header", "data_words", "trailer",
                                                    "back_pressure"};

    always #5 clk125 = ~clk125;  // 125 MHz nominal, 10 ns here

    wfd_top #(
        .NUM_CHAN   (NUM_CHAN),
        .FIFO_DEPTH (8)
    ) i_dut (
        .clk125 (clk125), .arst_n (arst_n), .ext_trig (ext_trig), .board_id (board_id),
        .acq_trigs (acq_trigs), .acq_dones (acq_dones), .trig_arm (trig_arm),
        .chan_tvalid (chan_tvalid), .chan_tlast (chan_tlast), .chan_tdata (chan_tdata),
        .chan_tready (chan_tready), .daq_valid (daq_valid), .daq_header (daq_header),
        .daq_trailer (daq_trailer), .daq_data (daq_data), .daq_ready (daq_ready)
    );

    ////////////////////////////////////////////////////
    // error reporting and expected words

    task automatic report_mismatch(input int idx, input logic [65:0] exp_val,
                                   input logic [65:0] act_val);
        errs[idx]++;
        $display("Mismatch %s: expected %h, actual %h", test_name[idx], exp_val, act_val);
    endtask

    task automatic report_fault(input int idx, input string msg);
        errs[idx]++;
        $display("%s: %s", test_name[idx], msg);
    endtask

    function automatic logic [65:0] header_word(input int idx);
        return {2'b10, 24'(idx), BOARD_ID, 3'(NUM_CHAN), 34'd0};
    endfunction

    function automatic logic [65:0] data_word(input int chan, input logic [31:0] payload);
        return {2'b00, 3'(chan), 29'd0, payload};
    endfunction

    function automatic logic [65:0] trailer_word(input int idx, input int cnt);
        return {2'b01, 24'(idx), 20'd0, 20'(cnt)};
    endfunction

    task automatic pulse_trigger(input int len);
        ext_trig <= 1'b1;
        repeat (len) @(posedge clk125);
        ext_trig <= 1'b0;
    endtask

    ////////////////////////////////////////////////////
    // checks

    assert property (@(posedge clk125) $rose(arst_n) |->
        acq_trigs == '0 && !daq_valid && chan_tready == '0 && trig_arm == '1)
        else report_fault(0, "outputs not at their reset values when reset was released");

    assert property (@(posedge clk125) disable iff (!arst_n) |acq_trigs |-> &acq_trigs)
        else report_mismatch(1, {NUM_CHAN{1'b1}}, $sampled(acq_trigs));
    assert property (@(posedge clk125) disable iff (!arst_n) |acq_trigs |=> !(|acq_trigs))
        else report_fault(1, "go pulse lasted more than one cycle");
    assert property (@(posedge clk125) disable iff (!arst_n) |acq_trigs |-> trig_arm == '0)
        else report_mismatch(1, '0, $sampled(trig_arm));
    assert property (@(posedge clk125) disable iff (!arst_n)
        dones_pending != '0 |-> trig_arm == '0)
        else report_fault(1, "trig_arm came back before every channel gave done");
    // edge seen through the synchronizer while still disarmed
    assert property (@(posedge clk125) disable iff (!arst_n)
        $rose(ext_trig) ##0 (trig_arm == '0) [*3] |=> !(|acq_trigs))
        else report_fault(1, "go issued for a trigger edge that arrived while disarmed");

    assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && daq_ready && exp_avail && exp_head[65] |->
        {daq_header, daq_trailer, daq_data} == exp_head)
        else report_mismatch(2, $sampled(exp_head), $sampled({daq_header, daq_trailer, daq_data}));
    assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && daq_ready && exp_avail && exp_head[65:64] == 2'b00 |->
        {daq_header, daq_trailer, daq_data} == exp_head)
        else report_mismatch(3, $sampled(exp_head), $sampled({daq_header, daq_trailer, daq_data}));
    assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && daq_ready && exp_avail && exp_head[64] |->
        {daq_header, daq_trailer, daq_data} == exp_head)
        else report_mismatch(4, $sampled(exp_head), $sampled({daq_header, daq_trailer, daq_data}));
    assert property (@(posedge clk125) disable iff (!arst_n) daq_valid && daq_ready |-> exp_avail)
        else report_fault(3, "DAQ word sent with no word left in the expected event");

    // stalled word must not move
    assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && !daq_ready |=> daq_valid && {daq_header, daq_trailer, daq_data} == held_word)
        else report_mismatch(5, $sampled(held_word), $sampled({daq_header, daq_trailer, daq_data}));

    ////////////////////////////////////////////////////
    // channel models, DAQ sink and expected event queue

    always @(posedge clk125) begin : model
        logic [65:0]            popped;
        logic [CHAN_DATA_W-1:0] pay;
        int                     total;
        dones_pending = dones_pending & ~acq_dones;  // dones the DUT sees at this edge
        acq_dones <= '0;
        daq_ready <= ($urandom % 4) != 0;  // ready three cycles out of four on average
        held_word = {daq_header, daq_trailer, daq_data};
        if (arst_n && !arst_q) hits[0]++;
        arst_q = arst_n;
        if (|acq_trigs) begin  // go, start the acquisition timers
            ev_idx = go_cnt;
            go_cnt++;
            hits[1]++;
            dones_pending = '1;
            for (int c = 0; c < NUM_CHAN; c++) countdown[c] = 1 + $urandom % 20;
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (chan_tvalid[c] && chan_tready[c]) void'(chan_q[c].pop_front());
            if (countdown[c] > 0) begin
                countdown[c]--;
                if (countdown[c] == 0) begin  // done, then this event's words are ready
                    acq_dones[c] <= 1'b1;
                    ev_len[c] = 1 + $urandom % 4;
                    for (int w = 0; w < ev_len[c]; w++) begin
                        pay = {ev_idx[15:0], 8'(c), 8'(w)};  // go count, channel, word
                        ev_words[c][w] = pay;
                        chan_q[c].push_back({w == ev_len[c] - 1, pay});
                    end
                    chans_done++;
                end
            end
            chan_tvalid[c] <= chan_q[c].size() > 0;
            chan_tlast[c]  <= chan_q[c].size() > 0 ? chan_q[c][0][32] : 1'b0;
            chan_tdata[c*CHAN_DATA_W +: CHAN_DATA_W] <= chan_q[c].size() > 0 ?
                                                        chan_q[c][0][31:0] : '0;
        end
        if (chans_done == NUM_CHAN) begin  // whole event known
            total = 0;
            exp_q.push_back(header_word(ev_idx));
            for (int c = 0; c < NUM_CHAN; c++) begin
                for (int w = 0; w < ev_len[c]; w++) exp_q.push_back(data_word(c, ev_words[c][w]));
                total += ev_len[c];
            end
            exp_q.push_back(trailer_word(ev_idx, total));
            chans_done = 0;
        end
        if (daq_valid && !daq_ready) hits[5]++;
        if (daq_valid && daq_ready && daq_header) hdr_cnt++;  // headers the DUT sent
        if (daq_valid && daq_ready && exp_q.size() > 0) begin
            popped = exp_q.pop_front();
            if (popped[65]) hits[2]++;
            else if (popped[64]) hits[4]++;
            else hits[3]++;
        end
        exp_avail = exp_q.size() > 0;
        exp_head  = exp_avail ? exp_q[0] : '0;
    end

    ////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        int          n_ok;
        int          n_err;
        void'($urandom(SEED));
        arst_n      = 1'b0;
        ext_trig    = 1'b0;
        board_id    = BOARD_ID;
        acq_dones   = '0;
        chan_tvalid = '0;
        chan_tlast  = '0;
        chan_tdata  = '0;
        daq_ready   = 1'b0;
        repeat (10) @(posedge clk125);
        arst_n <= 1'b1;
        for (int i = 0; i < N_TRIG; i++) begin
            repeat (2 + $urandom % 8) @(posedge clk125);
            while (trig_arm != '1) @(posedge clk125);
            pulse_trigger(2 + $urandom % 3);
            if (i % 2 == 1) begin  // extra edge while the channels acquire
                repeat (2) @(posedge clk125);
                if (trig_arm == '0) pulse_trigger(2);
            end
        end
        repeat (10) @(posedge clk125);
        while (exp_q.size() != 0 || dones_pending != '0) @(posedge clk125);
        repeat (20) @(posedge clk125);
        assert (hdr_cnt == go_cnt) else report_mismatch(5, go_cnt, hdr_cnt);
        n_ok  = 0;
        n_err = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            if (hits[t] == 0) begin
                $display("%s: FAIL, check was never exercised", test_name[t]);
                n_err++;
            end else if (errs[t] != 0) begin
                $display("%s: FAIL, %0d errors", test_name[t], errs[t]);
                n_err++;
            end else begin
                $display("%s: PASS, %0d hits", test_name[t], hits[t]);
                n_ok++;
            end
        end
        $display("summary: %0d tests, %0d ok, %0d with errors, %0d go pulses, %0d events",
                 N_TESTS, n_ok, n_err, go_cnt, hdr_cnt);
        if (n_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (N_TRIG * 500) @(posedge clk125);
        $display("timeout: run did not drain, %0d go pulses, %0d headers", go_cnt, hdr_cnt);
        $display("test failed");
        $finish;
    end

endmodule

// File: sources.f
wfd_pkg.sv
trigger_manager.sv
trig_num_fifo.sv
readout_manager.sv
wfd_top.sv
tb_wfd_top.sv
